/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////
// opcode field values
////////////////////////////////////////

// compact numbering held in instr[6:0].
`define RTYPE 7'd0
`define ITYPE 7'd1
`define STYPE 7'd2
`define BTYPE 7'd3
`define UTYPE 7'd4
`define JTYPE 7'd5

////////////////////////////////////////
// special func3 codes inside ITYPE
////////////////////////////////////////

`define LW_F3   3'b110 // load word.
`define JALR_F3 3'b111 // jump and link register.

////////////////////////////////////////
// core sizing
////////////////////////////////////////

`define RESET_PC 32'h0000_0000
`define NUM_REGS 32

`endif

/* rtl/core_pkg.sv */
package core_pkg;

    ////////////////////////////////////////
    // ALU selection
    ////////////////////////////////////////

    // coarse request from the main decoder.
    typedef enum logic [1:0] {
        ADD_CLASS,
        SUB_CLASS,
        FUNC_CLASS
    } aluClass_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOp_t;

    ////////////////////////////////////////
    // immediate and write-back selection
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } immSrc_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_LINK, // pc plus 4 for jal and jalr.
        RES_IMM
    } resultSrc_t;

    // one bundle per instruction, all zero means a no-op.
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrc;
        logic       jal;
        logic       jalr;
        logic       pcTaken;
        immSrc_t    immSrc;
        resultSrc_t resultSrc;
    } ctrl_t;

endpackage

/* rtl/Alu.sv */
module Alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  core_pkg::aluOp_t aluOp,
    output logic [31:0]      result,
    output logic             zero,
    output logic             neg
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // signed compare straight from the operands, so overflow cannot flip it.
    assign neg = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            core_pkg::ALU_ADD: result = a + b;
            core_pkg::ALU_SUB: result = a - b;
            core_pkg::ALU_SLL: result = a << shamt;
            core_pkg::ALU_SLT: result = {31'd0, neg};
            core_pkg::ALU_XOR: result = a ^ b;
            core_pkg::ALU_SRL: result = a >> shamt;
            core_pkg::ALU_SRA: result = $unsigned($signed(a) >>> shamt);
            core_pkg::ALU_OR:  result = a | b;
            core_pkg::ALU_AND: result = a & b;
            default:           result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

/* rtl/AluController.sv */
`include "core_settings.svh"

module AluController (
    input  core_pkg::aluClass_t aluClass,
    input  logic [2:0]          func3,
    input  logic                func7b5,
    input  logic                isRType,
    output core_pkg::aluOp_t    aluOp
);

    always_comb begin
        case (aluClass)
            core_pkg::SUB_CLASS: aluOp = core_pkg::ALU_SUB;
            core_pkg::FUNC_CLASS: begin
                case (func3)
                    3'b000: aluOp = (isRType && func7b5) ? core_pkg::ALU_SUB
                                                         : core_pkg::ALU_ADD;
                    3'b001: aluOp = core_pkg::ALU_SLL;
                    3'b010: aluOp = core_pkg::ALU_SLT;
                    3'b100: aluOp = core_pkg::ALU_XOR;
                    3'b101: aluOp = func7b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                    // in ITYPE these two codes are lw and jalr, both need rs1 plus imm.
                    `LW_F3:   aluOp = isRType ? core_pkg::ALU_OR : core_pkg::ALU_ADD;
                    `JALR_F3: aluOp = isRType ? core_pkg::ALU_AND : core_pkg::ALU_ADD;
                    default: aluOp = core_pkg::ALU_ADD;
                endcase
            end
            default: aluOp = core_pkg::ALU_ADD;
        endcase
    end

endmodule

/* rtl/ImmExtend.sv */
module ImmExtend (
    input  logic [31:7]       instr,
    input  core_pkg::immSrc_t immSrc,
    output logic [31:0]       imm
);

    always_comb begin
        case (immSrc)
            core_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            core_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            core_pkg::IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0}; // branch offsets are even.
            end
            core_pkg::IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            core_pkg::IMM_U: imm = {instr[31:12], 12'd0};
            default:         imm = 32'd0;
        endcase
    end

endmodule

/* rtl/RegFile.sv */
`include "core_settings.svh"

module RegFile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;
        end
    end

    // x0 is never written, so its entry is masked on read.
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* rtl/MainController.sv */
`include "core_settings.svh"

module MainController (
    input  logic [6:0]         op,
    input  logic [2:0]         func3,
    input  logic               zero,
    input  logic               neg,
    output core_pkg::ctrl_t    ctrl,
    output core_pkg::aluClass_t aluClass
);

    logic branchTaken;

    // the ALU subtracts rs2 from rs1 for every branch.
    always_comb begin
        case (func3)
            3'b000:  branchTaken = zero;
            3'b001:  branchTaken = ~zero;
            3'b100:  branchTaken = neg;
            3'b101:  branchTaken = ~neg;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        aluClass = core_pkg::ADD_CLASS;
        case (op)
            `RTYPE: begin
                ctrl.regWrite = 1'b1;
                aluClass      = core_pkg::FUNC_CLASS;
            end
            `ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = core_pkg::IMM_I;
                aluClass      = core_pkg::FUNC_CLASS; // loads and jalr are sorted out later.
                if (func3 == `LW_F3) begin
                    ctrl.resultSrc = core_pkg::RES_MEM;
                end else if (func3 == `JALR_F3) begin
                    ctrl.jalr      = 1'b1;
                    ctrl.pcTaken   = 1'b1;
                    ctrl.resultSrc = core_pkg::RES_LINK;
                end
            end
            `STYPE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = core_pkg::IMM_S;
            end
            `BTYPE: begin
                ctrl.immSrc  = core_pkg::IMM_B;
                ctrl.pcTaken = branchTaken;
                aluClass     = core_pkg::SUB_CLASS;
            end
            `UTYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = core_pkg::IMM_U;
                ctrl.resultSrc = core_pkg::RES_IMM;
            end
            `JTYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.pcTaken   = 1'b1;
                ctrl.immSrc    = core_pkg::IMM_J;
                ctrl.resultSrc = core_pkg::RES_LINK;
            end
            default: begin
                ctrl = '0; // Unknown opcode, nothing changes but the PC.
            end
        endcase
    end

endmodule

/* rtl/Datapath.sv */
`include "core_settings.svh"

module Datapath (
    input  logic             clk,
    input  logic             arstN,
    input  logic [31:0]      instr,
    input  core_pkg::ctrl_t  ctrl,
    input  core_pkg::aluOp_t aluOp,
    input  logic [31:0]      dataRdata,
    output logic [31:0]      instrAddr,
    output logic [31:0]      dataAddr,
    output logic [31:0]      dataWdata,
    output logic             dataWrite,
    output logic             zero,
    output logic             neg
);

    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] pcPlus4;
    logic        running;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic [31:0] result;

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////

    // the first edge after reset only arms the core, RESET_PC runs next.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= `RESET_PC;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) begin
                pc <= nextPc;
            end
        end
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.jalr) begin
            nextPc = {aluResult[31:1], 1'b0}; // rs1 plus imm, bit 0 dropped.
        end else if (ctrl.jal || ctrl.pcTaken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    ////////////////////////////////////////
    // execute and write-back
    ////////////////////////////////////////

    RegFile regFile (
        .clk (clk),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (instr[11:7]),
        .we  (ctrl.regWrite & running),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    ImmExtend immExtend (
        .instr  (instr[31:7]),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    assign srcB = ctrl.aluSrc ? imm : rd2;

    Alu alu (
        .a      (rd1),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (zero),
        .neg    (neg)
    );

    always_comb begin
        case (ctrl.resultSrc)
            core_pkg::RES_MEM:  result = dataRdata;
            core_pkg::RES_LINK: result = pcPlus4;
            core_pkg::RES_IMM:  result = imm;
            default:            result = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWdata = rd2;
    assign dataWrite = ctrl.memWrite & running; // Store gate.

endmodule

/* rtl/RiscCore.sv */
`include "core_settings.svh"

module RiscCore (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] instr,
    input  logic [31:0] dataRdata,
    output logic [31:0] instrAddr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWrite
);

    core_pkg::ctrl_t     ctrl;
    core_pkg::aluClass_t aluClass;
    core_pkg::aluOp_t    aluOp;
    logic                zero;
    logic                neg;
    logic                isRType;

    assign isRType = (instr[6:0] == `RTYPE); // func7 subtract only applies here.

    MainController mainController (
        .op       (instr[6:0]),
        .func3    (instr[14:12]),
        .zero     (zero),
        .neg      (neg),
        .ctrl     (ctrl),
        .aluClass (aluClass)
    );

    AluController aluController (
        .aluClass (aluClass),
        .func3    (instr[14:12]),
        .func7b5  (instr[30]),
        .isRType  (isRType),
        .aluOp    (aluOp)
    );

    Datapath datapath (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .ctrl      (ctrl),
        .aluOp     (aluOp),
        .dataRdata (dataRdata),
        .instrAddr (instrAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWrite (dataWrite),
        .zero      (zero),
        .neg       (neg)
    );

endmodule

/* sim/core_props.sv */
module core_props (
    input logic        clk,
    input logic        arstN,
    input logic [31:0] instrAddr,
    input logic        dataWrite
);

    int failCount = 0;

    noStoreInReset: assert property (@(posedge clk) !arstN |-> !dataWrite)
        else begin
            failCount++;
            $error("dataWrite high while arstN is low");
        end

    // fetch addresses stay on word boundaries once the core runs.
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instrAddr is not word aligned");
        end

    pcKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(instrAddr))
        else begin
            failCount++;
            $error("instrAddr holds unknown bits");
        end

endmodule

bind RiscCore core_props props (
    .clk       (clk),
    .arstN     (arstN),
    .instrAddr (instrAddr),
    .dataWrite (dataWrite)
);

/* sim/CoreChecker.sv */
`include "core_settings.svh"

module CoreChecker (
    input logic        clk,
    input logic        arstN,
    input logic [31:0] instr,
    input logic [31:0] dataRdata,
    input logic [31:0] instrAddr,
    input logic [31:0] dataAddr,
    input logic [31:0] dataWdata,
    input logic        dataWrite
);

    logic [31:0] regs [`NUM_REGS];
    logic [31:0] pc;
    logic        running;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] immI;
    logic [31:0] immS;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          errorsBefore = 0;

    assign rs1Val = regs[instr[19:15]];
    assign rs2Val = regs[instr[24:20]];
    assign immI   = {{20{instr[31]}}, instr[31:20]};
    assign immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // arithmetic shared by register and immediate forms.
    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportPhase(input string name);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d mismatches", testsRun, name,
                     errorCount - errorsBefore);
        end
        errorsBefore = errorCount;
    endtask

    ////////////////////////////////////////
    // instruction-level model
    ////////////////////////////////////////

    always @(posedge clk or negedge arstN) begin
        logic [31:0] nextPc;
        logic [31:0] wb;
        logic        wen;
        logic        taken;
        if (!arstN) begin
            pc      = `RESET_PC;
            running = 1'b0;
            regs[0] = 32'd0;
        end else if (!running) begin
            running = 1'b1; // first edge after reset executes nothing.
        end else begin
            nextPc = pc + 32'd4;
            wb     = pc + 32'd4;
            wen    = 1'b1;
            taken  = 1'b0;
            case (instr[6:0])
                `RTYPE: wb = arith(instr[14:12], instr[30], rs1Val, rs2Val);
                `ITYPE: begin
                    if (instr[14:12] == `LW_F3) begin
                        wb = dataRdata;
                    end else if (instr[14:12] == `JALR_F3) begin
                        nextPc = (rs1Val + immI) & ~32'd1;
                    end else begin
                        wb = arith(instr[14:12], instr[30] && instr[14:12] == 3'b101,
                                   rs1Val, immI);
                    end
                end
                `UTYPE: wb = {instr[31:12], 12'd0};
                `JTYPE: begin
                    nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
                end
                `BTYPE: begin
                    wen = 1'b0;
                    case (instr[14:12])
                        3'b000:  taken = rs1Val == rs2Val;
                        3'b001:  taken = rs1Val != rs2Val;
                        3'b100:  taken = $signed(rs1Val) < $signed(rs2Val);
                        3'b101:  taken = $signed(rs1Val) >= $signed(rs2Val);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25],
                                       instr[11:8], 1'b0};
                    end
                end
                default: wen = 1'b0; // stores and unknown opcodes write no register.
            endcase
            if (wen && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = wb;
            end
            pc = nextPc;
        end
    end

    // outputs are settled half a cycle after the inputs change.
    always @(negedge clk) begin
        logic isStore;
        logic isLoad;
        isStore = running && instr[6:0] == `STYPE;
        isLoad  = running && instr[6:0] == `ITYPE && instr[14:12] == `LW_F3;
        compare("instrAddr", pc, instrAddr);
        compare("dataWrite", {31'd0, isStore}, {31'd0, dataWrite});
        if (isStore) begin
            compare("dataAddr", rs1Val + immS, dataAddr);
            compare("dataWdata", rs2Val, dataWdata);
        end
        if (isLoad) begin
            compare("dataAddr", rs1Val + immI, dataAddr);
        end
    end

endmodule

/* sim/core_tb.sv */
`include "core_settings.svh"

module core_tb;

    localparam int clkPeriod   = 20;
    localparam int driveDelay  = 1;
    localparam int resetCycles = 10;
    localparam int phaseLen    = 400;
    localparam int numPhases   = 6;
    localparam int timeout     = numPhases * phaseLen * clkPeriod + 100 * clkPeriod;

    logic        clk;
    logic        arstN;
    logic [31:0] instr;
    logic [31:0] dataRdata;
    logic [31:0] instrAddr;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataWrite;
    logic [31:0] seed;

    RiscCore DUT (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .dataRdata (dataRdata),
        .instrAddr (instrAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWrite (dataWrite)
    );

    CoreChecker refCheck (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .dataRdata (dataRdata),
        .instrAddr (instrAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWrite (dataWrite)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // the low bits of an LCG repeat quickly, so the halves are swapped.
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    ////////////////////////////////////////
    // instruction generator
    ////////////////////////////////////////

    function automatic logic [31:0] makeInstr(input int favored);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] base;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] bOff;
        logic [20:0] jOff;
        logic [6:0]  op;
        int          kind;
        r    = nextRand();
        s    = nextRand();
        rd   = r[4:0];
        rs1  = r[9:5];
        rs2  = r[14:10];
        imm  = r[26:15];
        kind = r[27] ? favored : int'(r[31:29]) % 6; // half the picks go to the phase's class.
        case (kind)
            0: begin
                if (s[0]) begin
                    f3 = (s[3:1] == 3'b011) ? 3'b000 : s[3:1];
                    return {1'b0, s[4] && (f3 == 3'b000 || f3 == 3'b101), 5'd0,
                            rs2, rs1, f3, rd, `RTYPE};
                end
                f3 = (s[3:1] inside {3'b011, 3'b110, 3'b111}) ? 3'b000 : s[3:1];
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, s[4] && f3 == 3'b101, 5'd0, imm[4:0]};
                end
                return {imm, rs1, f3, rd, `ITYPE};
            end
            1: return {imm, rs1, `LW_F3, rd, `ITYPE};
            2: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `STYPE};
            3: begin
                if (s[21:20] == 2'b00) begin
                    rs2 = rs1; // equal operands now and then.
                end
                bOff = {s[16:6], 2'b00};
                return {bOff[12], bOff[10:5], rs2, rs1, s[19:17], bOff[4:1], bOff[11], `BTYPE};
            end
            4: begin
                if (s[0]) begin
                    jOff = {s[20:2], 2'b00};
                    return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, `JTYPE};
                end
                // the target lands on a word, sometimes with bit 0 set for the core to drop.
                base     = refCheck.regs[rs1];
                imm[1:0] = {1'b0, s[1]} - base[1:0];
                return {imm, rs1, `JALR_F3, rd, `ITYPE};
            end
            default: begin
                if (r[28]) begin
                    return {s[31:12], rd, `UTYPE};
                end
                op = (s[6:0] < 7'd6) ? s[6:0] + 7'd6 : s[6:0];
                return {s[31:7], op};
            end
        endcase
    endfunction

    function automatic string phaseName(input int p);
        case (p)
            0:       return "arithmetic";
            1:       return "loads";
            2:       return "stores";
            3:       return "branches";
            4:       return "jumps";
            default: return "upper immediates and invalid opcodes";
        endcase
    endfunction

    task automatic issueWord(input logic [31:0] word);
        @(posedge clk);
        #(driveDelay);
        instr     = word;
        dataRdata = nextRand();
    endtask

    task automatic issueRandom(input int favored);
        @(posedge clk);
        #(driveDelay);
        instr     = makeInstr(favored);
        dataRdata = nextRand();
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        seed      = 32'hd5a8_0640;
        arstN     = 1'b0;
        instr     = {25'd0, `STYPE};
        dataRdata = 32'd0;
        for (int i = 0; i < resetCycles; i++) begin
            r = nextRand();
            issueWord({r[31:15], 3'b010, r[11:7], `STYPE}); // stores held back by reset.
        end
        arstN = 1'b1;
        for (int i = 1; i < `NUM_REGS; i++) begin
            r = nextRand();
            issueWord({r[31:12], 5'(i), `UTYPE}); // gives every register a known value.
        end
        @(negedge clk);
        #(driveDelay);
        refCheck.reportPhase("reset and register setup");
        for (int p = 0; p < numPhases; p++) begin
            for (int i = 0; i < phaseLen; i++) begin
                issueRandom(p);
            end
            @(negedge clk);
            #(driveDelay);
            refCheck.reportPhase(phaseName(p));
        end
        @(negedge clk);
        #(driveDelay);
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 refCheck.testsRun, refCheck.testsFailed, refCheck.checkCount,
                 refCheck.errorCount, DUT.props.failCount);
        if (refCheck.errorCount == 0 && refCheck.testsFailed == 0
                && DUT.props.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(timeout);
        $display("watchdog expired, the run did not finish within %0d time units", timeout);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
rtl/core_pkg.sv
rtl/Alu.sv
rtl/AluController.sv
rtl/ImmExtend.sv
rtl/RegFile.sv
rtl/MainController.sv
rtl/Datapath.sv
rtl/RiscCore.sv
sim/core_props.sv
sim/CoreChecker.sv
sim/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
